/* Makefile */
# Verilator build, run, lint and clean for the cassette ADC path

VERILATOR ?= verilator
TOP       ?= tb_cas_adc
RTL_TOP   ?= cas_adc_top
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only if the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
hdl/cas_adc_pkg.sv
hdl/cas_sample_if.sv
hdl/adc_sample_capture.sv
hdl/sample_window.sv
hdl/cassette_slicer.sv
hdl/cas_adc_top.sv
tests/tb_cas_adc.sv

/* hdl/adc_sample_capture.sv */
// ADC capture stage that detects sync toggles, pushes samples on credit and counts drops
module adc_sample_capture #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                     clk_sys,
	input  logic                     i_reset,
	input  logic                     i_adc_sync,
	input  cas_adc_pkg::adc_sample_t i_adc_data,
	cas_sample_if.producer           smp,
	output cas_adc_pkg::drop_count_t o_drop_count
);
	import cas_adc_pkg::*;

	localparam int CW = $clog2(QUEUE_DEPTH + 1);

	logic              sync_q;
	logic              sync_d;
	adc_sample_t       data_q;
	logic [CW-1:0]     credits;
	logic              toggle;
	logic              have_credit;
	logic              push_fire;

	//////////////////////////////////////////////////
	// Sync line and data capture
	//////////////////////////////////////////////////

	// Either edge of the sync line marks a new conversion
	assign toggle = sync_q ^ sync_d;
	assign have_credit = (credits != '0);
	assign push_fire = toggle && have_credit;

	// Load both stages from the line in reset
	// Avoids a false toggle when the line idles high
	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			sync_q <= i_adc_sync;
			sync_d <= i_adc_sync;
		end
		else
		begin
			sync_q <= i_adc_sync;
			sync_d <= sync_q;
		end
	end

	// Data registered alongside the sync line
	always_ff @(posedge clk_sys)
	begin
		data_q <= i_adc_data;
		if (push_fire)
			smp.sample <= data_q;
	end

	//////////////////////////////////////////////////
	// Credits and push
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			credits  <= CW'(QUEUE_DEPTH);
			smp.push <= 1'b0;
		end
		else
		begin
			smp.push <= push_fire;
			// Spend a credit on push and regain one on return
			// A push and a return on the same cycle cancel out
			case ({push_fire, smp.credit_return})
				2'b10:   credits <= credits - CW'(1);
				2'b01:   credits <= credits + CW'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Drops happen only when all credits are out
	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
			o_drop_count <= '0;
		else if (toggle && !have_credit && (o_drop_count != '1))
			o_drop_count <= o_drop_count + 1'b1;
	end

	// After a push at least one credit is out with the buffer
	a_push_had_credit: assert property (@(posedge clk_sys) disable iff (i_reset)
		smp.push |-> (credits < CW'(QUEUE_DEPTH)));

	// Buffer never returns more credits than were handed out
	a_credit_bound: assert property (@(posedge clk_sys) disable iff (i_reset)
		(credits <= CW'(QUEUE_DEPTH)) &&
		!(smp.credit_return && (credits == CW'(QUEUE_DEPTH))));

endmodule

/* hdl/cas_adc_pkg.sv */
// Cassette ADC package with sample, audio and counter types plus default sizes
package cas_adc_pkg;

	//////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////

	// One conversion from the 12-bit audio ADC
	typedef logic [11:0] adc_sample_t;

	// Sound level coming from the machine core
	typedef logic [11:0] machine_sound_t;

	// Assembled word for the audio sink
	// Speaker bit on top, then sound, then three zero bits
	typedef logic [15:0] audio_word_t;

	// Dropped-sample counter, saturates at all ones
	typedef logic [15:0] drop_count_t;

	//////////////////////////////////////////////////
	// Defaults and constants
	//////////////////////////////////////////////////

	// 2^9 = 512 samples in the averaging window
	// Roughly a 100 Hz high-pass at 48 kHz sampling
	localparam int DEFAULT_WINDOW_LOG2 = 9;

	// Input queue depth in the window buffer
	// Same value is the producer's credit count after reset
	localparam int DEFAULT_QUEUE_DEPTH = 4;

	// Hysteresis distance around the running average
	// 100 counts is about 0.1 V on the ADC input
	localparam int THRESHOLD = 100;

endpackage

/* hdl/cas_adc_top.sv */
// Cassette ADC path top level joining capture, window buffer and slicer
module cas_adc_top #(
	parameter int WINDOW_LOG2 = cas_adc_pkg::DEFAULT_WINDOW_LOG2,
	parameter int QUEUE_DEPTH = cas_adc_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  logic                        clk_sys,
	input  logic                        i_reset,
	input  logic                        i_adc_sync,
	input  cas_adc_pkg::adc_sample_t    i_adc_data,
	input  cas_adc_pkg::machine_sound_t i_sound,
	input  logic                        i_snd_bit,
	input  logic                        i_monitor,
	input  logic                        i_audio_ready,
	output cas_adc_pkg::audio_word_t    o_audio,
	output logic                        o_audio_valid,
	output logic                        o_cas_bit,
	output cas_adc_pkg::drop_count_t    o_drop_count
);

	// Buffer to slicer link
	logic                     win_valid;
	logic                     win_ready;
	cas_adc_pkg::adc_sample_t win_new;
	cas_adc_pkg::adc_sample_t win_old;

	// Producer to buffer, samples forward and credits back
	cas_sample_if u_sample_if ();

	//////////////////////////////////////////////////
	// Capture, buffer, slicer
	//////////////////////////////////////////////////

	adc_sample_capture #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_capture (
		.clk_sys      (clk_sys),
		.i_reset      (i_reset),
		.i_adc_sync   (i_adc_sync),
		.i_adc_data   (i_adc_data),
		.smp          (u_sample_if.producer),
		.o_drop_count (o_drop_count)
	);

	sample_window #(
		.WINDOW_LOG2 (WINDOW_LOG2),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_window (
		.clk_sys      (clk_sys),
		.i_reset      (i_reset),
		.smp          (u_sample_if.buffer),
		.i_ready      (win_ready),
		.o_valid      (win_valid),
		.o_new_sample (win_new),
		.o_old_sample (win_old)
	);

	cassette_slicer #(
		.WINDOW_LOG2 (WINDOW_LOG2)
	) u_slicer (
		.clk_sys       (clk_sys),
		.i_reset       (i_reset),
		.i_valid       (win_valid),
		.i_new_sample  (win_new),
		.i_old_sample  (win_old),
		.i_sound       (i_sound),
		.i_snd_bit     (i_snd_bit),
		.i_monitor     (i_monitor),
		.i_audio_ready (i_audio_ready),
		.o_ready       (win_ready),
		.o_audio       (o_audio),
		.o_audio_valid (o_audio_valid),
		.o_cas_bit     (o_cas_bit)
	);

endmodule

/* hdl/cas_sample_if.sv */
// Sample link from the ADC capture stage to the window buffer with credit return
interface cas_sample_if;
	import cas_adc_pkg::*;

	// One-cycle strobe, a sample is being handed over
	logic push;

	// Sample payload, valid with push
	adc_sample_t sample;

	// One-cycle strobe, one queue slot has been freed
	logic credit_return;

	// Capture side
	// Spends credits on push, collects them back from the buffer
	modport producer (
		output push,
		output sample,
		input  credit_return
	);

	// Buffer side
	// Accepts pushes, returns a credit per entry moved into the window
	modport buffer (
		input  push,
		input  sample,
		output credit_return
	);

endinterface

/* hdl/cassette_slicer.sv */
// Cassette slicer with running average, hysteresis bit and audio word output under back-pressure
module cassette_slicer #(
	parameter int WINDOW_LOG2 = 9
) (
	input  logic                        clk_sys,
	input  logic                        i_reset,
	input  logic                        i_valid,
	input  cas_adc_pkg::adc_sample_t    i_new_sample,
	input  cas_adc_pkg::adc_sample_t    i_old_sample,
	input  cas_adc_pkg::machine_sound_t i_sound,
	input  logic                        i_snd_bit,
	input  logic                        i_monitor,
	input  logic                        i_audio_ready,
	output logic                        o_ready,
	output cas_adc_pkg::audio_word_t    o_audio,
	output logic                        o_audio_valid,
	output logic                        o_cas_bit
);
	import cas_adc_pkg::*;

	localparam int SW    = $bits(adc_sample_t);
	localparam int SUM_W = SW + WINDOW_LOG2;
	// Two spare bits so avg +/- THRESHOLD never wraps
	localparam int CMP_W = SW + 2;

	logic [SUM_W-1:0]        sum_q;
	logic [SUM_W-1:0]        sum_next;
	adc_sample_t             avg;
	logic signed [CMP_W-1:0] smp_s;
	logic signed [CMP_W-1:0] lo_s;
	logic signed [CMP_W-1:0] hi_s;
	logic                    cas_q;
	logic                    cas_next;
	audio_word_t             word_next;

	//////////////////////////////////////////////////
	// Running sum and average
	//////////////////////////////////////////////////

	// Average from the sum before this sample goes in
	assign avg = adc_sample_t'(sum_q >> WINDOW_LOG2);

	// Add the newcomer, remove the sample leaving the window
	assign sum_next = sum_q + SUM_W'(i_new_sample) - SUM_W'(i_old_sample);

	//////////////////////////////////////////////////
	// Hysteresis slicer
	//////////////////////////////////////////////////

	assign smp_s = $signed(CMP_W'(i_new_sample));
	assign lo_s  = $signed(CMP_W'(avg)) - $signed(CMP_W'(THRESHOLD));
	assign hi_s  = $signed(CMP_W'(avg)) + $signed(CMP_W'(THRESHOLD));

	// Low swing sets the bit, high swing clears it
	// Inverted polarity, as on the original machine
	always_comb
	begin
		cas_next = cas_q;
		if (smp_s < lo_s)
			cas_next = 1'b1;
		else if (smp_s > hi_s)
			cas_next = 1'b0;
	end

	// Speaker loudest, then machine sound
	// Monitored tape bit sits low in the mix at sound bit 5
	assign word_next = {i_snd_bit, i_sound[11:6], i_sound[5] ^ (cas_next & i_monitor),
		i_sound[4:0], 3'b000};

	//////////////////////////////////////////////////
	// Output register and handshake
	//////////////////////////////////////////////////

	// Nothing in flight and the output is free or leaving now
	assign o_ready = !i_valid && (!o_audio_valid || i_audio_ready);

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			sum_q         <= '0;
			cas_q         <= 1'b0;
			o_audio_valid <= 1'b0;
		end
		else if (i_valid)
		begin
			sum_q         <= sum_next;
			cas_q         <= cas_next;
			o_audio_valid <= 1'b1;
		end
		else if (i_audio_ready)
			o_audio_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys)
	begin
		if (i_valid)
			o_audio <= word_next;
	end

	assign o_cas_bit = cas_q;

	// Word holds until the sink takes it
	a_audio_stable: assert property (@(posedge clk_sys) disable iff (i_reset)
		(o_audio_valid && !i_audio_ready) |=> (o_audio_valid && $stable(o_audio)));

	// Buffer only delivers into an empty output register
	a_accept_when_free: assert property (@(posedge clk_sys) disable iff (i_reset)
		i_valid |-> !o_audio_valid);

endmodule

/* hdl/sample_window.sv */
// Window buffer with an input queue and a circular memory pairing new and retiring samples
module sample_window #(
	parameter int WINDOW_LOG2 = 9,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                     clk_sys,
	input  logic                     i_reset,
	cas_sample_if.buffer             smp,
	input  logic                     i_ready,
	output logic                     o_valid,
	output cas_adc_pkg::adc_sample_t o_new_sample,
	output cas_adc_pkg::adc_sample_t o_old_sample
);
	import cas_adc_pkg::*;

	localparam int QW  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW  = $clog2(QUEUE_DEPTH + 1);
	localparam int WIN = 1 << WINDOW_LOG2;

	adc_sample_t             q_mem [QUEUE_DEPTH];
	logic [QW-1:0]           q_wr_ptr;
	logic [QW-1:0]           q_rd_ptr;
	logic [CW-1:0]           q_count;
	logic                    q_empty;
	logic                    take;
	adc_sample_t             q_head;
	adc_sample_t             win_mem [WIN];
	logic [WINDOW_LOG2-1:0]  win_ptr;
	logic                    win_wrapped;

	// Queue pointer step, wraps for any depth
	function automatic logic [QW-1:0] q_step(input logic [QW-1:0] ptr);
		if (ptr == QW'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + QW'(1);
	endfunction

	//////////////////////////////////////////////////
	// Input queue
	//////////////////////////////////////////////////

	assign q_empty = (q_count == '0);
	assign q_head = q_mem[q_rd_ptr];

	// Move one entry when the consumer has room
	assign take = i_ready && !q_empty;

	always_ff @(posedge clk_sys)
	begin
		if (smp.push)
			q_mem[q_wr_ptr] <= smp.sample;
	end

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			q_wr_ptr          <= '0;
			q_rd_ptr          <= '0;
			q_count           <= '0;
			smp.credit_return <= 1'b0;
		end
		else
		begin
			if (smp.push)
				q_wr_ptr <= q_step(q_wr_ptr);
			if (take)
				q_rd_ptr <= q_step(q_rd_ptr);
			case ({smp.push, take})
				2'b10:   q_count <= q_count + CW'(1);
				2'b01:   q_count <= q_count - CW'(1);
				default: q_count <= q_count;
			endcase
			// Slot freed, hand its credit back
			smp.credit_return <= take;
		end
	end

	//////////////////////////////////////////////////
	// Circular window
	//////////////////////////////////////////////////

	// Slot at the pointer holds the oldest sample
	// Read before write on the same edge gives the retiring one
	// Until the first wrap the window is still all zeros
	always_ff @(posedge clk_sys)
	begin
		if (take)
		begin
			win_mem[win_ptr] <= q_head;
			o_new_sample     <= q_head;
			o_old_sample     <= win_wrapped ? win_mem[win_ptr] : '0;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			win_ptr     <= '0;
			win_wrapped <= 1'b0;
			o_valid     <= 1'b0;
		end
		else
		begin
			o_valid <= take;
			if (take)
			begin
				win_ptr <= win_ptr + 1'b1;
				if (&win_ptr)
					win_wrapped <= 1'b1;
			end
		end
	end

	// Credit flow keeps the queue from overflowing
	a_no_push_when_full: assert property (@(posedge clk_sys) disable iff (i_reset)
		smp.push |-> (q_count != CW'(QUEUE_DEPTH)));

endmodule

/* tests/cas_adc_golden.txt */
# sample sound spk mon ready expected_audio expected_cas, all hex, window of 16 from zeros
# ready = stall cycles before the sink takes the word, f = back-pressure burst (last group)
640 000 0 0 0 0000 0
640 fff 1 0 1 fff8 0
032 123 0 0 0 0918 1
640 abc 1 0 2 d5e0 0
104 5a5 0 0 0 2d28 0
0c8 820 1 0 3 c100 1
190 3c7 0 0 0 1e38 1
3e8 7e0 1 0 1 bf00 0
12c 400 0 1 0 2100 1
1f4 9e7 1 1 2 ce38 1
258 555 0 1 1 2aa8 0
1e0 2aa 1 1 0 9550 0
064 2aa 1 1 3 9450 1
000 555 0 1 0 2ba8 1
2bc fff 0 1 1 7ff8 0
fff 001 1 1 0 8008 0
2bc fff 0 1 2 7ef8 1
320 000 1 1 0 8100 1
7d0 6b3 1 1 f b598 0
12c 6b3 1 1 f b498 1
320 6b3 1 1 f b498 1
5dc 6b3 1 1 f b598 0
352 6b3 1 1 f b598 0
0c8 6b3 1 1 f b498 1
384 6b3 1 1 f b498 1
bb8 6b3 1 1 f b598 0
3e8 6b3 1 1 f b598 0
1f4 6b3 1 1 f b498 1
44c 6b3 1 1 f b498 1
9c4 6b3 1 1 f b598 0

/* tests/tb_cas_adc.sv */
// Testbench for the cassette ADC path, golden samples in, audio words and cassette bit checked
module tb_cas_adc;
	import cas_adc_pkg::*;

	localparam int MAX_LINES  = 64;
	localparam int WAIT_LIMIT = 200;

	logic           clk_sys;
	logic           i_reset;
	logic           i_adc_sync;
	adc_sample_t    i_adc_data;
	machine_sound_t i_sound;
	logic           i_snd_bit;
	logic           i_monitor;
	logic           i_audio_ready;
	audio_word_t    o_audio;
	logic           o_audio_valid;
	logic           o_cas_bit;
	drop_count_t    o_drop_count;

	// Golden columns, one entry per sample line
	adc_sample_t    g_sample [MAX_LINES];
	machine_sound_t g_sound [MAX_LINES];
	logic           g_spk [MAX_LINES];
	logic           g_mon [MAX_LINES];
	logic [3:0]     g_ready [MAX_LINES];
	audio_word_t    g_word [MAX_LINES];
	logic           g_cas [MAX_LINES];
	int             n_lines;
	int             err_count;
	int             check_count;
	logic           aborted;

	cas_adc_top #(
		.WINDOW_LOG2 (4)
	) u_cas_adc_top (
		.clk_sys       (clk_sys),
		.i_reset       (i_reset),
		.i_adc_sync    (i_adc_sync),
		.i_adc_data    (i_adc_data),
		.i_sound       (i_sound),
		.i_snd_bit     (i_snd_bit),
		.i_monitor     (i_monitor),
		.i_audio_ready (i_audio_ready),
		.o_audio       (o_audio),
		.o_audio_valid (o_audio_valid),
		.o_cas_bit     (o_cas_bit),
		.o_drop_count  (o_drop_count)
	);

	// 4-unit clock period
	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			err_count++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic read_golden();
		int    fd;
		int    got;
		string line;
		fd = $fopen("tests/cas_adc_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the golden file tests/cas_adc_golden.txt");
			err_count++;
			aborted = 1'b1;
			return;
		end
		while (!$feof(fd) && n_lines < MAX_LINES)
		begin
			line = "";
			got = $fgets(line, fd);
			// Comment and blank lines carry no sample
			if (got > 0 && line.len() > 1 && line[0] != "#")
			begin
				got = $sscanf(line, "%h %h %h %h %h %h %h", g_sample[n_lines], g_sound[n_lines],
					g_spk[n_lines], g_mon[n_lines], g_ready[n_lines], g_word[n_lines],
					g_cas[n_lines]);
				if (got == 7)
					n_lines++;
			end
		end
		$fclose(fd);
	endtask

	// Poll for a pending audio word, gives up after WAIT_LIMIT cycles
	task automatic wait_word(input string what, output int cycles);
		cycles = 0;
		while (!o_audio_valid && cycles < WAIT_LIMIT)
		begin
			next_cycle();
			cycles++;
		end
		if (!o_audio_valid)
		begin
			$display("Timed out waiting for an audio word during %s", what);
			err_count++;
			aborted = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// One sample through the whole path
	//////////////////////////////////////////////////

	task automatic run_sample(input int idx);
		int          cycles;
		audio_word_t held;
		i_adc_data = g_sample[idx];
		i_sound = g_sound[idx];
		i_snd_bit = g_spk[idx];
		i_monitor = g_mon[idx];
		i_audio_ready = (g_ready[idx] == 4'h0);
		i_adc_sync = ~i_adc_sync;
		wait_word($sformatf("sample %0d", idx), cycles);
		if (aborted)
			return;
		check_value($sformatf("latency %0d", idx), 32'd1, 32'(cycles >= 4));
		check_value($sformatf("audio %0d", idx), 32'(g_word[idx]), 32'(o_audio));
		check_value($sformatf("cas bit %0d", idx), 32'(g_cas[idx]), 32'(o_cas_bit));
		held = o_audio;
		// Sink stalls, word sits still
		repeat (g_ready[idx])
		begin
			next_cycle();
			check_value($sformatf("stall valid %0d", idx), 32'd1, 32'(o_audio_valid));
			check_value($sformatf("stall audio %0d", idx), 32'(held), 32'(o_audio));
		end
		i_audio_ready = 1'b1;
		next_cycle();
		check_value($sformatf("idle after %0d", idx), 32'd0, 32'(o_audio_valid));
		repeat ($urandom % 4)
			next_cycle();
	endtask

	//////////////////////////////////////////////////
	// Burst against a stalled sink
	//////////////////////////////////////////////////

	task automatic run_burst(input int first, input int last);
		int          total;
		int          delivered;
		int          quiet;
		int          cycles;
		int          k;
		audio_word_t held;
		total = last - first + 1;
		i_audio_ready = 1'b0;
		i_sound = g_sound[first];
		i_snd_bit = g_spk[first];
		i_monitor = g_mon[first];
		for (k = first; k <= last; k++)
		begin
			i_adc_data = g_sample[k];
			i_adc_sync = ~i_adc_sync;
			repeat (2 + $urandom % 3)
				next_cycle();
		end
		wait_word("burst", cycles);
		if (aborted)
			return;
		check_value("burst first audio", 32'(g_word[first]), 32'(o_audio));
		held = o_audio;
		// Queue full, credits gone, word still parked
		repeat (20)
		begin
			next_cycle();
			check_value("burst hold valid", 32'd1, 32'(o_audio_valid));
			check_value("burst hold audio", 32'(held), 32'(o_audio));
			check_value("burst hold cas", 32'(g_cas[first]), 32'(o_cas_bit));
		end
		check_value("burst caused drops", 32'd1, 32'(o_drop_count != '0));
		i_audio_ready = 1'b1;
		delivered = 0;
		quiet = 0;
		// Drain until the path stays idle
		while (quiet < 20 && delivered <= total)
		begin
			if (o_audio_valid && delivered < total)
			begin
				check_value($sformatf("burst audio %0d", first + delivered),
					32'(g_word[first + delivered]), 32'(o_audio));
				check_value($sformatf("burst cas %0d", first + delivered),
					32'(g_cas[first + delivered]), 32'(o_cas_bit));
				delivered++;
				quiet = 0;
			end
			else if (o_audio_valid)
			begin
				$display("An audio word came out beyond the burst length");
				err_count++;
				delivered++;
			end
			else
				quiet++;
			next_cycle();
		end
		check_value("delivered plus drops", 32'(total), 32'(delivered + int'(o_drop_count)));
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int first;
		int idx;
		err_count = 0;
		check_count = 0;
		n_lines = 0;
		aborted = 1'b0;
		i_reset = 1'b1;
		i_adc_sync = 1'b0;
		i_adc_data = '0;
		i_sound = '0;
		i_snd_bit = 1'b0;
		i_monitor = 1'b0;
		i_audio_ready = 1'b0;
		void'($urandom(32'h9dee810b));
		read_golden();
		repeat (10) @(posedge clk_sys);
		#1;
		i_reset = 1'b0;
		next_cycle();
		check_value("reset valid", 32'd0, 32'(o_audio_valid));
		check_value("reset cas", 32'd0, 32'(o_cas_bit));
		check_value("reset drops", 32'd0, 32'(o_drop_count));
		if (n_lines == 0 && !aborted)
		begin
			$display("The golden file holds no sample lines");
			err_count++;
		end
		idx = 0;
		while (!aborted && idx < n_lines)
		begin
			if (g_ready[idx] != 4'hf)
			begin
				run_sample(idx);
				idx++;
			end
			else
			begin
				first = idx;
				while (idx < n_lines && g_ready[idx] == 4'hf)
					idx++;
				check_value("drops before burst", 32'd0, 32'(o_drop_count));
				run_burst(first, idx - 1);
			end
		end
		$display("Checks run: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
